// ==== flist.f ====
+incdir+verilog
verilog/pixel_pkg.sv
verilog/track_pkg.sv
verilog/pixel_classifier.sv
verilog/centroid_divider.sv
verilog/centroid_accumulator.sv
verilog/motion_tracker.sv
verilog/led_tracker_top.sv
test/led_tracker_assertions.sv
test/led_tracker_tb.sv

// ==== Bender.yml ====
package:
  name: led_tracker

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pixel_pkg.sv
      - verilog/track_pkg.sv
      - verilog/pixel_classifier.sv
      - verilog/centroid_divider.sv
      - verilog/centroid_accumulator.sv
      - verilog/motion_tracker.sv
      - verilog/led_tracker_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - test/led_tracker_assertions.sv
      - test/led_tracker_tb.sv

// ==== test/led_tracker_tb.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module led_tracker_tb
    import pixel_pkg::*, track_pkg::*;
();

    localparam int CLK_HALF_NS   = 20;
    localparam int WINDOW        = `TRACK_WINDOW_FRAMES;
    localparam int NUM_ROWS      = 16;
    // three full windows plus a partial one cut by reset and one more
    localparam int TOTAL_FRAMES  = 3 * NUM_ROWS + 7 + NUM_ROWS;
    // two 8x8 rectangles, filler, frame gap and divider
    localparam int WORST_FRAME   = 2 * 64 + 40 + 50;
    localparam int CENTROID_WAIT = 64;

    // one frame of stimulus plus what each player should report
    typedef struct packed {
        int red_x;
        int red_y;
        int red_w;
        int red_h;
        int red_col;
        int white_x;
        int white_y;
        int white_w;
        int white_h;
        int white_col;
        int filler;
        int p1_found;
        int p1_x;
        int p1_y;
        int p2_found;
        int p2_x;
        int p2_y;
    } frame_row_t;

    logic           clk_65mhz;
    logic           reset;
    pixel_beat_t    pixel_in;
    logic           frame_done;
    centroid_t      p1_centroid;
    centroid_t      p2_centroid;
    motion_report_t p1_motion;
    motion_report_t p2_motion;

    frame_row_t rows [NUM_ROWS];

    // reference window model with index 0 for red and 1 for white
    int model_cur_x [2];
    int model_cur_y [2];
    int model_sum_x [2];
    int model_sum_y [2];
    // sign of a zero total
    bit model_neg_x [2];
    bit model_neg_y [2];
    int model_frames;

    led_tracker_top i_dut (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .pixel_in    (pixel_in),
        .frame_done  (frame_done),
        .p1_centroid (p1_centroid),
        .p2_centroid (p2_centroid),
        .p1_motion   (p1_motion),
        .p2_motion   (p2_motion)
    );

    bind led_tracker_top led_tracker_assertions i_assertions (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .p1_centroid (p1_centroid),
        .p2_centroid (p2_centroid),
        .p1_motion   (p1_motion),
        .p2_motion   (p2_motion)
    );

    initial clk_65mhz = 1'b0;
    always #(CLK_HALF_NS) clk_65mhz = ~clk_65mhz;

    // watchdog sized from the frame count
    initial begin
        #((TOTAL_FRAMES * WORST_FRAME + 100) * 2 * CLK_HALF_NS);
        $display("timeout: the frame sequence did not finish in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // red rect, white rect, filler, p1 found/x/y, p2 found/x/y
    task automatic fill_table();
        rows[0]  = '{40, 50, 4, 3, 'hF00, 200, 100, 3, 3, 'hFFF, 10, 1, 41, 51, 1, 201, 101};
        rows[1]  = '{60, 70, 5, 4, 'hD00, 180, 90, 4, 4, 'hDDD, 20, 1, 62, 71, 1, 181, 91};
        // red nibble of 12 is not bright
        rows[2]  = '{60, 70, 5, 4, 'hC00, 150, 80, 3, 5, 'hEEE, 15, 0, 0, 0, 1, 151, 82};
        // four and five lit pixels are both too few
        rows[3]  = '{90, 40, 2, 2, 'hF00, 120, 60, 5, 1, 'hFFF, 5, 0, 0, 0, 0, 0, 0};
        rows[4]  = '{100, 30, 3, 2, 'hF11, 120, 60, 6, 1, 'hFFF, 8, 1, 101, 30, 1, 122, 60};
        rows[5]  = '{20, 200, 6, 5, 'hE20, 300, 10, 4, 3, 'hFEF, 12, 1, 22, 202, 1, 301, 11};
        rows[6]  = '{250, 150, 3, 3, 'hF00, 10, 220, 5, 3, 'hFFF, 0, 1, 251, 151, 1, 12, 221};
        rows[7]  = '{30, 20, 4, 4, 'hF00, 280, 200, 3, 4, 'hFFF, 25, 1, 31, 21, 1, 281, 201};
        rows[8]  = '{310, 230, 4, 4, 'hF00, 0, 0, 3, 3, 'hFFF, 30, 1, 311, 231, 1, 1, 1};
        rows[9]  = '{160, 120, 7, 5, 'hF00, 161, 130, 5, 5, 'hFFF, 40, 1, 163, 122, 1, 163, 132};
        // green of 3 is not dark
        rows[10] = '{150, 110, 3, 3, 'hF30, 170, 100, 4, 2, 'hFFF, 10, 0, 0, 0, 1, 171, 100};
        rows[11] = '{140, 100, 5, 5, 'hF00, 175, 105, 3, 3, 'hD3D, 10, 1, 142, 102, 0, 0, 0};
        // red stands still
        rows[12] = '{140, 100, 5, 5, 'hF00, 175, 105, 3, 3, 'hFFF, 10, 1, 142, 102, 1, 176, 106};
        rows[13] = '{80, 60, 4, 4, 'hF00, 230, 170, 6, 4, 'hFFF, 20, 1, 81, 61, 1, 232, 171};
        rows[14] = '{70, 90, 3, 6, 'hF00, 240, 180, 2, 2, 'hFFF, 10, 1, 71, 92, 0, 0, 0};
        rows[15] = '{200, 150, 4, 2, 'hF00, 50, 40, 5, 3, 'hFFF, 16, 1, 201, 150, 1, 52, 41};
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk_65mhz);
        #2;
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic model_clear_window();
        int p;
        for (p = 0; p < 2; p++) begin
            model_sum_x[p] = 0;
            model_sum_y[p] = 0;
            model_neg_x[p] = 1'b0;
            model_neg_y[p] = 1'b0;
        end
        model_frames = 0;
    endtask

    task automatic model_reset();
        int p;
        for (p = 0; p < 2; p++) begin
            model_cur_x[p] = 0;
            model_cur_y[p] = 0;
        end
        model_clear_window();
    endtask

    // lost led holds the coordinate with a zero positive delta
    task automatic model_axis(inout int sum, inout bit neg, inout int cur,
                              input int found, input int new_c);
        int next;
        next = (found != 0) ? new_c : cur;
        sum  = sum + next - cur;
        neg  = next < cur;
        cur  = next;
    endtask

    // {sign, magnitude} as the report packs it
    function automatic logic [31:0] axis_expect(input int sum, input bit neg);
        logic [31:0] mag;
        logic        sign;
        sign = (sum < 0) || (sum == 0 && neg);
        mag  = (sum < 0) ? -sum : sum;
        return {18'd0, sign, mag[12:0]};
    endfunction

    //////////////////////////////
    // frame driving and checks
    //////////////////////////////

    task automatic send_rect(input int x0, input int y0, input int w, input int h,
                             input int col);
        int xx;
        int yy;
        for (yy = 0; yy < h; yy++) begin
            for (xx = 0; xx < w; xx++) begin
                advance_cycle();
                pixel_in = '{1'b1, 12'(col), 9'(x0 + xx), 8'(y0 + yy)};
            end
        end
    endtask

    task automatic send_frame(input int idx);
        frame_row_t r;
        int         n;
        r = rows[idx];
        send_rect(r.red_x, r.red_y, r.red_w, r.red_h, r.red_col);
        send_rect(r.white_x, r.white_y, r.white_w, r.white_h, r.white_col);
        // dark background anywhere in the frame
        for (n = 0; n < r.filler; n++) begin
            advance_cycle();
            pixel_in = '{1'b1,
                         {4'($urandom % 3), 4'($urandom % 3), 4'($urandom % 3)},
                         9'($urandom % `TRACK_FRAME_WIDTH),
                         8'($urandom % `TRACK_FRAME_HEIGHT)};
        end
        advance_cycle();
        pixel_in.valid = 1'b0;
        frame_done     = 1'b1;
        repeat (3) advance_cycle();
        // falling edge closes the frame
        frame_done = 1'b0;
    endtask

    task automatic wait_centroid();
        int cycles;
        cycles = 0;
        @(negedge clk_65mhz);
        while (!p1_centroid.valid && cycles < CENTROID_WAIT) begin
            cycles++;
            @(negedge clk_65mhz);
        end
        if (!p1_centroid.valid) begin
            $display("no centroid came back within %0d cycles of the frame end",
                     CENTROID_WAIT);
            $display("SIMULATION FAILED");
            $fatal(1, "centroid wait expired");
        end
    endtask

    task automatic check_frame(input int idx);
        frame_row_t r;
        bit         report;
        r = rows[idx];
        check_value("p2_centroid.valid", 32'(p2_centroid.valid), 1);
        check_value("p1_centroid.found", 32'(p1_centroid.found), r.p1_found);
        check_value("p2_centroid.found", 32'(p2_centroid.found), r.p2_found);
        if (r.p1_found != 0) begin
            check_value("p1_centroid.x", 32'(p1_centroid.x), r.p1_x);
            check_value("p1_centroid.y", 32'(p1_centroid.y), r.p1_y);
        end
        if (r.p2_found != 0) begin
            check_value("p2_centroid.x", 32'(p2_centroid.x), r.p2_x);
            check_value("p2_centroid.y", 32'(p2_centroid.y), r.p2_y);
        end
        model_axis(model_sum_x[0], model_neg_x[0], model_cur_x[0], r.p1_found, r.p1_x);
        model_axis(model_sum_y[0], model_neg_y[0], model_cur_y[0], r.p1_found, r.p1_y);
        model_axis(model_sum_x[1], model_neg_x[1], model_cur_x[1], r.p2_found, r.p2_x);
        model_axis(model_sum_y[1], model_neg_y[1], model_cur_y[1], r.p2_found, r.p2_y);
        report = model_frames == WINDOW - 1;
        // report lands one cycle after the centroid
        @(negedge clk_65mhz);
        check_value("p1_motion.valid", 32'(p1_motion.valid), 32'(report));
        check_value("p2_motion.valid", 32'(p2_motion.valid), 32'(report));
        if (report) begin
            check_value("p1_motion.x", 32'(p1_motion.x),
                        axis_expect(model_sum_x[0], model_neg_x[0]));
            check_value("p1_motion.y", 32'(p1_motion.y),
                        axis_expect(model_sum_y[0], model_neg_y[0]));
            check_value("p2_motion.x", 32'(p2_motion.x),
                        axis_expect(model_sum_x[1], model_neg_x[1]));
            check_value("p2_motion.y", 32'(p2_motion.y),
                        axis_expect(model_sum_y[1], model_neg_y[1]));
            model_clear_window();
        end else begin
            model_frames++;
        end
    endtask

    // rows taken in a ring from start
    task automatic run_frames(input int start, input int count);
        int k;
        int idx;
        for (k = 0; k < count; k++) begin
            idx = (start + k) % NUM_ROWS;
            send_frame(idx);
            wait_centroid();
            check_frame(idx);
        end
    endtask

    // three cycles of reset with every output checked while it is held
    task automatic apply_reset();
        reset      = 1'b1;
        pixel_in   = '0;
        frame_done = 1'b0;
        advance_cycle();
        @(negedge clk_65mhz);
        check_value("p1_centroid", 32'(p1_centroid), 0);
        check_value("p2_centroid", 32'(p2_centroid), 0);
        check_value("p1_motion", 32'(p1_motion), 0);
        check_value("p2_motion", 32'(p2_motion), 0);
        advance_cycle();
        advance_cycle();
        reset = 1'b0;
        model_reset();
    endtask

    initial begin
        void'($urandom(32'hd042167c));
        fill_table();
        apply_reset();
        // first window measured from zero
        run_frames(0, NUM_ROWS);
        // same path again ending where it started
        run_frames(0, NUM_ROWS);
        // rotated so red moves back and white moves forward
        run_frames(8, NUM_ROWS);
        // cut short by reset
        run_frames(0, 7);
        advance_cycle();
        apply_reset();
        run_frames(0, NUM_ROWS);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== test/led_tracker_assertions.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module led_tracker_assertions
    import pixel_pkg::*, track_pkg::*;
(
    input logic           clk_65mhz,
    input logic           reset,
    input centroid_t      p1_centroid,
    input centroid_t      p2_centroid,
    input motion_report_t p1_motion,
    input motion_report_t p2_motion
);

    logic [3:0] valids;

    assign valids = {p1_centroid.valid, p2_centroid.valid, p1_motion.valid, p2_motion.valid};

    //////////////////////////////
    // handshake shape
    //////////////////////////////

    // every valid is a one-cycle pulse
    single_pulse: assert property (@(posedge clk_65mhz) disable iff (reset)
        (valids & $past(valids)) == 4'b0)
        else $error("a valid stayed high for more than one cycle");

    // report only right after a centroid
    p1_motion_after_centroid: assert property (@(posedge clk_65mhz) disable iff (reset)
        p1_motion.valid |-> $past(p1_centroid.valid))
        else $error("p1 motion report without a centroid the cycle before");

    p2_motion_after_centroid: assert property (@(posedge clk_65mhz) disable iff (reset)
        p2_motion.valid |-> $past(p2_centroid.valid))
        else $error("p2 motion report without a centroid the cycle before");

    quiet_in_reset: assert property (@(posedge clk_65mhz)
        reset |=> valids == 4'b0)
        else $error("a valid was high while reset was applied");

    //////////////////////////////
    // centroid range
    //////////////////////////////

    p1_in_frame: assert property (@(posedge clk_65mhz) disable iff (reset)
        p1_centroid.valid && p1_centroid.found |->
            p1_centroid.x < `TRACK_FRAME_WIDTH && p1_centroid.y < `TRACK_FRAME_HEIGHT)
        else $error("p1 centroid outside the frame");

    p2_in_frame: assert property (@(posedge clk_65mhz) disable iff (reset)
        p2_centroid.valid && p2_centroid.found |->
            p2_centroid.x < `TRACK_FRAME_WIDTH && p2_centroid.y < `TRACK_FRAME_HEIGHT)
        else $error("p2 centroid outside the frame");

endmodule

// ==== verilog/led_tracker_top.sv ====
`timescale 1ns/10ps

module led_tracker_top
    import pixel_pkg::*, track_pkg::*;
(
    input  logic           clk_65mhz,
    input  logic           reset,
    input  pixel_beat_t    pixel_in,
    // high between frames
    input  logic           frame_done,
    output centroid_t      p1_centroid,
    output centroid_t      p2_centroid,
    output motion_report_t p1_motion,
    output motion_report_t p2_motion
);

    player_hits_t hits;
    logic         frame_close;

    //////////////////////////////
    // shared front end
    //////////////////////////////

    pixel_classifier i_classifier (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .pixel_in    (pixel_in),
        .frame_done  (frame_done),
        .hits        (hits),
        .frame_close (frame_close)
    );

    //////////////////////////////
    // per player, red then white
    //////////////////////////////

    centroid_accumulator i_acc_p1 (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .hit         (hits.hit_p1),
        .x           (hits.x),
        .y           (hits.y),
        .frame_close (frame_close),
        .centroid    (p1_centroid)
    );

    centroid_accumulator i_acc_p2 (
        .clk_65mhz   (clk_65mhz),
        .reset       (reset),
        .hit         (hits.hit_p2),
        .x           (hits.x),
        .y           (hits.y),
        .frame_close (frame_close),
        .centroid    (p2_centroid)
    );

    motion_tracker i_motion_p1 (
        .clk_65mhz (clk_65mhz),
        .reset     (reset),
        .centroid  (p1_centroid),
        .motion    (p1_motion)
    );

    motion_tracker i_motion_p2 (
        .clk_65mhz (clk_65mhz),
        .reset     (reset),
        .centroid  (p2_centroid),
        .motion    (p2_motion)
    );

endmodule

// ==== verilog/motion_tracker.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module motion_tracker
    import pixel_pkg::*, track_pkg::*;
(
    input  logic           clk_65mhz,
    input  logic           reset,
    input  centroid_t      centroid,
    output motion_report_t motion
);

    localparam int WIN   = `TRACK_WINDOW_FRAMES;
    localparam int WIN_W = $clog2(WIN);

    // last accepted coordinate is the reference for the next delta
    coord_x_t     cur_x;
    coord_y_t     cur_y;
    axis_motion_t total_x;
    axis_motion_t total_y;
    axis_motion_t delta_x;
    axis_motion_t delta_y;
    axis_motion_t next_x;
    axis_motion_t next_y;
    logic [WIN_W-1:0] frame_idx;
    logic         last_frame;
    logic         report_valid;
    axis_motion_t report_x;
    axis_motion_t report_y;

    //////////////////////////////
    // sign-magnitude helpers
    //////////////////////////////

    // new minus old
    function automatic axis_motion_t axis_delta(input logic [8:0] new_c,
                                                input logic [8:0] old_c);
        axis_motion_t d;
        d.sign = old_c > new_c;
        d.mag  = d.sign ? old_c - new_c : new_c - old_c;
        return d;
    endfunction

    // add one frame's delta into a window total
    function automatic axis_motion_t axis_fold(input axis_motion_t total,
                                               input axis_motion_t delta);
        axis_motion_t sum;
        if (total.sign == delta.sign) begin
            sum.sign = total.sign;
            sum.mag  = total.mag + delta.mag;
        end else if (total.mag > delta.mag) begin
            sum.sign = total.sign;
            sum.mag  = total.mag - delta.mag;
        end else begin
            // a tie lands here as zero with the new sign
            sum.sign = delta.sign;
            sum.mag  = delta.mag - total.mag;
        end
        return sum;
    endfunction

    always_comb begin
        // lost led means no movement this frame
        if (centroid.found) begin
            delta_x = axis_delta(centroid.x, cur_x);
            delta_y = axis_delta({1'b0, centroid.y}, {1'b0, cur_y});
        end else begin
            delta_x = '0;
            delta_y = '0;
        end
        next_x     = axis_fold(total_x, delta_x);
        next_y     = axis_fold(total_y, delta_y);
        last_frame = frame_idx == WIN_W'(WIN - 1);
    end

    //////////////////////////////
    // window state
    //////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            cur_x        <= '0;
            cur_y        <= '0;
            total_x      <= '0;
            total_y      <= '0;
            frame_idx    <= '0;
            report_valid <= 1'b0;
        end else begin
            report_valid <= centroid.valid && last_frame;
            if (centroid.valid) begin
                if (centroid.found) begin
                    cur_x <= centroid.x;
                    cur_y <= centroid.y;
                end
                // next window starts from zero
                if (last_frame) begin
                    frame_idx <= '0;
                    total_x   <= '0;
                    total_y   <= '0;
                end else begin
                    frame_idx <= frame_idx + 1'b1;
                    total_x   <= next_x;
                    total_y   <= next_y;
                end
            end
        end
    end

    // report includes the closing frame
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            report_x <= '0;
            report_y <= '0;
        end else if (centroid.valid && last_frame) begin
            report_x <= next_x;
            report_y <= next_y;
        end
    end

    assign motion = '{valid: report_valid, x: report_x, y: report_y};

endmodule

// ==== verilog/centroid_accumulator.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module centroid_accumulator
    import pixel_pkg::*, track_pkg::*;
(
    input  logic      clk_65mhz,
    input  logic      reset,
    input  logic      hit,
    input  coord_x_t  x,
    input  coord_y_t  y,
    input  logic      frame_close,
    output centroid_t centroid
);

    localparam int SUM_W = `TRACK_SUM_WIDTH;
    localparam int CNT_W = `TRACK_COUNT_WIDTH;

    logic [CNT_W-1:0] run_count;
    logic [SUM_W-1:0] run_x_sum;
    logic [SUM_W-1:0] run_y_sum;
    logic [CNT_W-1:0] frame_count;
    logic [SUM_W-1:0] frame_x_sum;
    logic [SUM_W-1:0] frame_y_sum;
    logic             accept;
    logic             div_start;
    logic             div_busy;
    logic             found_q;
    coord_x_t         x_quot;
    coord_y_t         y_quot;
    logic             x_done;
    logic             y_done;

    // close while dividing is dropped
    assign accept = frame_close && !div_busy;

    //////////////////////////////
    // running totals
    //////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (reset || accept) begin
            run_count <= '0;
            run_x_sum <= '0;
            run_y_sum <= '0;
        end else if (hit) begin
            run_count <= run_count + 1'b1;
            run_x_sum <= run_x_sum + x;
            run_y_sum <= run_y_sum + y;
        end
    end

    // frame snapshot, held for the whole division
    always_ff @(posedge clk_65mhz) begin
        if (accept) begin
            frame_count <= run_count;
            frame_x_sum <= run_x_sum;
            frame_y_sum <= run_y_sum;
        end
    end

    // divider kick and busy window
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            div_start <= 1'b0;
            div_busy  <= 1'b0;
            found_q   <= 1'b0;
        end else begin
            div_start <= accept;
            if (accept) begin
                div_busy <= 1'b1;
                // too few pixels, also covers divide by zero
                found_q  <= run_count > `TRACK_MIN_PIXELS;
            end else if (x_done) begin
                div_busy <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // dividers
    //////////////////////////////

    centroid_divider #(.quotient_t(coord_x_t)) i_div_x (
        .clk_65mhz (clk_65mhz),
        .reset     (reset),
        .start     (div_start),
        .dividend  (frame_x_sum),
        .divisor   (frame_count),
        .quotient  (x_quot),
        .done      (x_done)
    );

    centroid_divider #(.quotient_t(coord_y_t)) i_div_y (
        .clk_65mhz (clk_65mhz),
        .reset     (reset),
        .start     (div_start),
        .dividend  (frame_y_sum),
        .divisor   (frame_count),
        .quotient  (y_quot),
        .done      (y_done)
    );

    // both dividers finish together
    assign centroid = '{valid: x_done && y_done, found: found_q, x: x_quot, y: y_quot};

endmodule

// ==== verilog/centroid_divider.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module centroid_divider #(
    parameter type quotient_t = logic [8:0]
) (
    input  logic                          clk_65mhz,
    input  logic                          reset,
    input  logic                          start,
    input  logic [`TRACK_SUM_WIDTH-1:0]   dividend,
    input  logic [`TRACK_COUNT_WIDTH-1:0] divisor,
    output quotient_t                     quotient,
    output logic                          done
);

    localparam int SUM_W  = `TRACK_SUM_WIDTH;
    localparam int CNT_W  = `TRACK_COUNT_WIDTH;
    localparam int STEP_W = $clog2(SUM_W + 1);
    localparam int QUO_W  = $bits(quotient_t);

    logic              busy;
    logic [STEP_W-1:0] steps_left;
    logic [CNT_W-1:0]  rem_q;
    logic [CNT_W-1:0]  divisor_q;
    // dividend shifts out the top while quotient bits shift in at the bottom
    logic [SUM_W-1:0]  quo_q;
    logic [CNT_W:0]    trial;
    logic              fits;

    // remainder stays below the divisor so 17 bits hold the trial
    always_comb begin
        trial = {rem_q, quo_q[SUM_W-1]};
        fits  = trial >= {1'b0, divisor_q};
    end

    //////////////////////////////
    // step control
    //////////////////////////////

    // start ignored until the last bit is out
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            busy       <= 1'b0;
            steps_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy       <= 1'b1;
                    steps_left <= STEP_W'(SUM_W);
                end
            end else begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // one quotient bit per cycle
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            rem_q     <= '0;
            quo_q     <= '0;
            divisor_q <= '0;
        end else if (!busy && start) begin
            rem_q     <= '0;
            quo_q     <= dividend;
            divisor_q <= divisor;
        end else if (busy) begin
            rem_q <= fits ? CNT_W'(trial - {1'b0, divisor_q}) : trial[CNT_W-1:0];
            quo_q <= {quo_q[SUM_W-2:0], fits};
        end
    end

    // floor quotient with the upper bits dropped
    assign quotient = quo_q[QUO_W-1:0];

endmodule

// ==== verilog/pixel_classifier.sv ====
`timescale 1ns/10ps

`include "track_config.svh"

module pixel_classifier
    import pixel_pkg::*, track_pkg::*;
(
    input  logic         clk_65mhz,
    input  logic         reset,
    input  pixel_beat_t  pixel_in,
    input  logic         frame_done,
    output player_hits_t hits,
    output logic         frame_close
);

    logic red_bright;
    logic green_bright;
    logic blue_bright;
    logic green_dark;
    logic blue_dark;
    logic p1_pixel;
    logic p2_pixel;
    logic frame_done_d;

    //////////////////////////////
    // nibble tests
    //////////////////////////////

    always_comb begin
        red_bright   = pixel_in.color.r > `TRACK_HI_LEVEL;
        green_bright = pixel_in.color.g > `TRACK_HI_LEVEL;
        blue_bright  = pixel_in.color.b > `TRACK_HI_LEVEL;
        green_dark   = pixel_in.color.g < `TRACK_LO_LEVEL;
        blue_dark    = pixel_in.color.b < `TRACK_LO_LEVEL;
        // red led, strong red only
        p1_pixel = pixel_in.valid && red_bright && green_dark && blue_dark;
        // white led, player 1 wins any overlap
        p2_pixel = pixel_in.valid && red_bright && green_bright && blue_bright && !p1_pixel;
    end

    // one cycle of latency on the hit path
    always_ff @(posedge clk_65mhz) begin
        hits.x <= pixel_in.x;
        hits.y <= pixel_in.y;
        if (reset) begin
            hits.hit_p1 <= 1'b0;
            hits.hit_p2 <= 1'b0;
        end else begin
            hits.hit_p1 <= p1_pixel;
            hits.hit_p2 <= p2_pixel;
        end
    end

    //////////////////////////////
    // end of frame
    //////////////////////////////

    // frame_done high between frames, close on its falling edge
    always_ff @(posedge clk_65mhz) begin
        if (reset) begin
            frame_done_d <= 1'b0;
            frame_close  <= 1'b0;
        end else begin
            frame_done_d <= frame_done;
            frame_close  <= frame_done_d && !frame_done;
        end
    end

endmodule

// ==== verilog/track_pkg.sv ====
package track_pkg;

    import pixel_pkg::*;

    `include "track_config.svh"

    //////////////////////////////
    // per-beat classification
    //////////////////////////////

    // at most one hit bit set per beat
    typedef struct packed {
        logic     hit_p1;
        logic     hit_p2;
        coord_x_t x;
        coord_y_t y;
    } player_hits_t;

    //////////////////////////////
    // per-frame result
    //////////////////////////////

    // valid pulses once per frame
    // x and y only meaningful with found set
    typedef struct packed {
        logic     valid;
        logic     found;
        coord_x_t x;
        coord_y_t y;
    } centroid_t;

    // sign-magnitude, sign 1 = negative
    typedef struct packed {
        logic                           sign;
        logic [`TRACK_MOTION_WIDTH-1:0] mag;
    } axis_motion_t;

    // one report per window
    typedef struct packed {
        logic         valid;
        axis_motion_t x;
        axis_motion_t y;
    } motion_report_t;

endpackage

// ==== verilog/pixel_pkg.sv ====
package pixel_pkg;

    //////////////////////////////
    // camera pixel stream types
    //////////////////////////////

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // column 0..319
    typedef logic [8:0] coord_x_t;
    // row 0..239
    typedef logic [7:0] coord_y_t;

    // one beat, 30 bits
    // coordinates arrive with the colour
    typedef struct packed {
        logic     valid;
        rgb444_t  color;
        coord_x_t x;
        coord_y_t y;
    } pixel_beat_t;

endpackage

// ==== verilog/track_config.svh ====
`ifndef TRACK_CONFIG_SVH
`define TRACK_CONFIG_SVH

//////////////////////////////
// colour detection levels
//////////////////////////////

// nibble strictly above this is bright
`define TRACK_HI_LEVEL 12
// nibble strictly below this is dark
`define TRACK_LO_LEVEL 3
// count must exceed this for a usable centroid
`define TRACK_MIN_PIXELS 5

//////////////////////////////
// frame and window geometry
//////////////////////////////

`define TRACK_WINDOW_FRAMES 16
`define TRACK_FRAME_WIDTH 320
`define TRACK_FRAME_HEIGHT 240

// datapath widths
`define TRACK_SUM_WIDTH 24
`define TRACK_COUNT_WIDTH 16
`define TRACK_MOTION_WIDTH 13

`endif
